// ==== design/glyph_renderer.sv ====
module glyph_renderer (
	input  logic       clk,
	input  logic       rst,
	input  logic [9:0] h_addr,
	input  logic [9:0] v_addr,
	input  logic [7:0] last_key,
	input  logic       key_valid,
	output logic       pixel
);

	logic       in_rows;
	logic [7:0] row_sel;
	logic [7:0] row_bits;
	logic [2:0] col;
	logic       in_box;

	assign in_rows = (v_addr < 10'd16);

	// glyph row lookup for the current line
	always_comb begin
		row_sel = 8'h00;
		if (key_valid) begin
			case (last_key)
				kbd_pkg::KEY_Q: row_sel = kbd_pkg::GLYPH_Q[v_addr[3:0]];
				kbd_pkg::KEY_D: row_sel = kbd_pkg::GLYPH_D[v_addr[3:0]];
				default:        row_sel = 8'h00;
			endcase
		end
	end

	// stage 1
	always_ff @(posedge clk) begin
		if (in_rows)
			row_bits <= row_sel;
		col <= h_addr[2:0];
	end

	always_ff @(posedge clk) begin
		if (rst)
			in_box <= 1'b0;
		else
			in_box <= in_rows && (h_addr < 10'd8);
	end

	// stage 2, msb is the left edge
	always_ff @(posedge clk) begin
		if (rst)
			pixel <= 1'b0;
		else
			pixel <= in_box & row_bits[3'd7 - col];
	end

endmodule

// ==== design/kbd_display_top.sv ====
module kbd_display_top (
	input  logic        clk,
	input  logic        rst,
	input  logic        ps2_clk,
	input  logic        ps2_data,
	output logic        vga_hsync,
	output logic        vga_vsync,
	output logic        vga_blank_n,
	output logic [7:0]  vga_r,
	output logic [7:0]  vga_g,
	output logic [7:0]  vga_b,
	output logic [7:0]  seg0,
	output logic [7:0]  seg1,
	output logic [7:0]  seg4,
	output logic [7:0]  seg5,
	output logic [15:0] ledr
);

	logic [7:0] code;
	logic       code_valid;
	logic       parity_error;
	logic [7:0] last_key;
	logic       key_valid;
	logic [3:0] release_count;
	logic [9:0] h_addr;
	logic [9:0] v_addr;
	logic       pixel;

	ps2_receiver ps2_receiver_inst (
		.clk          (clk),
		.rst          (rst),
		.ps2_clk      (ps2_clk),
		.ps2_data     (ps2_data),
		.code         (code),
		.code_valid   (code_valid),
		.parity_error (parity_error)
	);

	key_event_decoder key_event_decoder_inst (
		.clk           (clk),
		.rst           (rst),
		.code          (code),
		.code_valid    (code_valid),
		.last_key      (last_key),
		.key_valid     (key_valid),
		.release_count (release_count)
	);

	vga_timing vga_timing_inst (
		.clk     (clk),
		.rst     (rst),
		.h_addr  (h_addr),
		.v_addr  (v_addr),
		.hsync   (vga_hsync),
		.vsync   (vga_vsync),
		.blank_n (vga_blank_n)
	);

	glyph_renderer glyph_renderer_inst (
		.clk       (clk),
		.rst       (rst),
		.h_addr    (h_addr),
		.v_addr    (v_addr),
		.last_key  (last_key),
		.key_valid (key_valid),
		.pixel     (pixel)
	);

	seg_display seg_display_inst (
		.last_key      (last_key),
		.key_valid     (key_valid),
		.release_count (release_count),
		.seg0          (seg0),
		.seg1          (seg1),
		.seg4          (seg4),
		.seg5          (seg5)
	);

	// white glyph on black
	assign vga_r = {8{pixel}};
	assign vga_g = {8{pixel}};
	assign vga_b = {8{pixel}};

	// top led unused
	assign ledr = {1'b0, last_key, release_count, key_valid, parity_error, pixel};

endmodule

// ==== design/kbd_pkg.sv ====
package kbd_pkg;

	// 640x480 at the pixel clock
	localparam logic [9:0] H_ACTIVE = 10'd640;
	localparam logic [9:0] H_FRONT  = 10'd16;
	localparam logic [9:0] H_SYNC   = 10'd96;
	localparam logic [9:0] H_BACK   = 10'd48;
	localparam logic [9:0] H_TOTAL  = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;

	localparam logic [9:0] V_ACTIVE = 10'd480;
	localparam logic [9:0] V_FRONT  = 10'd10;
	localparam logic [9:0] V_SYNC   = 10'd2;
	localparam logic [9:0] V_BACK   = 10'd33;
	localparam logic [9:0] V_TOTAL  = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;

	// set 2 scan code prefixes
	localparam logic [7:0] BREAK_CODE = 8'hF0;
	localparam logic [7:0] EXT_CODE   = 8'hE0;

	localparam logic [7:0] KEY_Q = 8'h15;
	localparam logic [7:0] KEY_D = 8'h23;

	// bit 7 is the leftmost pixel
	localparam logic [7:0] GLYPH_Q [0:15] = '{
		8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h76, 8'hCC, 8'hCC,
		8'hCC, 8'hCC, 8'hCC, 8'h7C, 8'h0C, 8'h0C, 8'h1E, 8'h00
	};
	localparam logic [7:0] GLYPH_D [0:15] = '{
		8'h00, 8'h00, 8'h1C, 8'h0C, 8'h0C, 8'h3C, 8'h6C, 8'hCC,
		8'hCC, 8'hCC, 8'hCC, 8'h76, 8'h00, 8'h00, 8'h00, 8'h00
	};

	// segments a..g in bits 7..1, dp in bit 0, active high
	localparam logic [7:0] SEG_HEX [0:15] = '{
		8'hFC, 8'h60, 8'hDA, 8'hF2, 8'h66, 8'hB6, 8'hBE, 8'hE0,
		8'hFE, 8'hF6, 8'hEE, 8'h3E, 8'h9C, 8'h7A, 8'h9E, 8'h8E
	};

	// depth of the glyph renderer pipeline
	localparam int PIX_DELAY = 2;

endpackage

// ==== design/key_event_decoder.sv ====
module key_event_decoder (
	input  logic       clk,
	input  logic       rst,
	input  logic [7:0] code,
	input  logic       code_valid,
	output logic [7:0] last_key,
	output logic       key_valid,
	output logic [3:0] release_count
);

	// two states: idle, or an F0 seen and waiting for the key
	logic break_pend;
	logic is_ext;
	logic is_break;

	assign is_ext   = (code == kbd_pkg::EXT_CODE);
	assign is_break = (code == kbd_pkg::BREAK_CODE);

	always_ff @(posedge clk) begin
		if (rst) begin
			break_pend    <= 1'b0;
			last_key      <= 8'h00;
			key_valid     <= 1'b0;
			release_count <= 4'd0;
		end else if (code_valid) begin
			if (is_ext) begin
				// extended keys are treated like their plain codes
				break_pend <= break_pend;
			end else if (is_break) begin
				break_pend <= 1'b1;
			end else if (break_pend) begin
				// release, last_key stays put
				break_pend    <= 1'b0;
				release_count <= release_count + 4'd1;
			end else begin
				last_key  <= code;
				key_valid <= 1'b1;
			end
		end
	end

endmodule

// ==== design/ps2_receiver.sv ====
module ps2_receiver (
	input  logic       clk,
	input  logic       rst,
	input  logic       ps2_clk,
	input  logic       ps2_data,
	output logic [7:0] code,
	output logic       code_valid,
	output logic       parity_error
);

	logic [1:0]  clk_sync;
	logic [1:0]  data_sync;
	logic        clk_prev;
	logic        fall;
	logic [3:0]  bit_cnt;
	logic [10:0] shift;
	logic [10:0] frame;
	logic        frame_ok;
	logic        parity_ok;

	// both lines idle high
	always_ff @(posedge clk) begin
		if (rst) begin
			clk_sync  <= 2'b11;
			data_sync <= 2'b11;
			clk_prev  <= 1'b1;
		end else begin
			clk_sync  <= {clk_sync[0], ps2_clk};
			data_sync <= {data_sync[0], ps2_data};
			clk_prev  <= clk_sync[1];
		end
	end

	assign fall = clk_prev & ~clk_sync[1];

	// lsb first, so the start bit ends up in bit 0
	assign frame     = {data_sync[1], shift[10:1]};
	assign frame_ok  = ~frame[0] & frame[10];
	assign parity_ok = ^frame[9:1];

	always_ff @(posedge clk) begin
		if (fall)
			shift <= frame;
		if (fall && bit_cnt == 4'd10)
			code <= frame[8:1];
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			bit_cnt      <= 4'd0;
			code_valid   <= 1'b0;
			parity_error <= 1'b0;
		end else begin
			code_valid <= 1'b0;
			if (fall) begin
				if (bit_cnt == 4'd10) begin
					bit_cnt <= 4'd0;
					if (frame_ok && parity_ok)
						code_valid <= 1'b1;
					else if (frame_ok)
						parity_error <= 1'b1;
				end else if (bit_cnt != 4'd0 || !data_sync[1]) begin
					// wait for a low start bit before counting
					bit_cnt <= bit_cnt + 4'd1;
				end
			end
		end
	end

endmodule

// ==== design/seg_display.sv ====
module seg_display (
	input  logic [7:0] last_key,
	input  logic       key_valid,
	input  logic [3:0] release_count,
	output logic [7:0] seg0,
	output logic [7:0] seg1,
	output logic [7:0] seg4,
	output logic [7:0] seg5
);

	// displays are active low, all ones is blank
	localparam logic [7:0] SEG_OFF = 8'hFF;

	logic [7:0] key_lo;
	logic [7:0] key_hi;
	logic [7:0] rel_pat;

	assign key_lo  = kbd_pkg::SEG_HEX[last_key[3:0]];
	assign key_hi  = kbd_pkg::SEG_HEX[last_key[7:4]];
	assign rel_pat = kbd_pkg::SEG_HEX[release_count];

	// nothing to show until the first key press
	assign seg0 = key_valid ? ~key_lo : SEG_OFF;
	assign seg1 = key_valid ? ~key_hi : SEG_OFF;

	assign seg4 = ~rel_pat;
	// upper digit of the release count, always zero
	assign seg5 = ~kbd_pkg::SEG_HEX[0];

endmodule

// ==== design/vga_timing.sv ====
module vga_timing (
	input  logic       clk,
	input  logic       rst,
	output logic [9:0] h_addr,
	output logic [9:0] v_addr,
	output logic       hsync,
	output logic       vsync,
	output logic       blank_n
);

	localparam int D = kbd_pkg::PIX_DELAY;

	logic [9:0]   h_cnt;
	logic [9:0]   v_cnt;
	logic         hs_raw;
	logic         vs_raw;
	logic         active_raw;
	logic [D-1:0] hs_pipe;
	logic [D-1:0] vs_pipe;
	logic [D-1:0] act_pipe;

	always_ff @(posedge clk) begin
		if (rst) begin
			h_cnt <= 10'd0;
			v_cnt <= 10'd0;
		end else if (h_cnt == kbd_pkg::H_TOTAL - 10'd1) begin
			h_cnt <= 10'd0;
			if (v_cnt == kbd_pkg::V_TOTAL - 10'd1)
				v_cnt <= 10'd0;
			else
				v_cnt <= v_cnt + 10'd1;
		end else begin
			h_cnt <= h_cnt + 10'd1;
		end
	end

	assign h_addr = h_cnt;
	assign v_addr = v_cnt;

	// syncs are active low
	assign hs_raw = !(h_cnt >= kbd_pkg::H_ACTIVE + kbd_pkg::H_FRONT &&
		h_cnt < kbd_pkg::H_ACTIVE + kbd_pkg::H_FRONT + kbd_pkg::H_SYNC);
	assign vs_raw = !(v_cnt >= kbd_pkg::V_ACTIVE + kbd_pkg::V_FRONT &&
		v_cnt < kbd_pkg::V_ACTIVE + kbd_pkg::V_FRONT + kbd_pkg::V_SYNC);
	assign active_raw = (h_cnt < kbd_pkg::H_ACTIVE) && (v_cnt < kbd_pkg::V_ACTIVE);

	// delay to line up with the renderer output
	always_ff @(posedge clk) begin
		if (rst) begin
			hs_pipe  <= '1;
			vs_pipe  <= '1;
			act_pipe <= '0;
		end else begin
			hs_pipe  <= {hs_pipe[D-2:0], hs_raw};
			vs_pipe  <= {vs_pipe[D-2:0], vs_raw};
			act_pipe <= {act_pipe[D-2:0], active_raw};
		end
	end

	assign hsync   = hs_pipe[D-1];
	assign vsync   = vs_pipe[D-1];
	assign blank_n = act_pipe[D-1];

endmodule

// ==== files.f ====
design/kbd_pkg.sv
design/ps2_receiver.sv
design/key_event_decoder.sv
design/vga_timing.sv
design/glyph_renderer.sv
design/seg_display.sv
design/kbd_display_top.sv
tests/tb_clock.sv
tests/kbd_display_checker.sv
tests/kbd_display_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the keyboard display testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f files.f --top-module kbd_display_tb -o kbd_display_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

output=$(./obj_dir/kbd_display_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "test passed"; then
	exit 0
fi
exit 1

// ==== tests/kbd_display_checker.sv ====
module kbd_display_checker (
	input logic       clk,
	input logic       rst,
	input logic       vga_hsync,
	input logic       vga_vsync,
	input logic       vga_blank_n,
	input logic [7:0] vga_r,
	input logic [7:0] vga_g,
	input logic [7:0] vga_b,
	input logic       led_pixel,
	input logic [9:0] h_addr,
	input logic [9:0] v_addr,
	input logic [7:0] last_key,
	input logic       key_valid,
	input logic       code_valid,
	input logic       parity_error
);

	int         fail_count = 0;
	logic       hs_prev;
	logic       hs_rise;
	logic       seen_rise;
	logic [9:0] since_rise;
	logic [9:0] low_len;
	logic [7:0] glyph_row;
	logic       exp_pixel;

	assign hs_rise = vga_hsync & ~hs_prev;

	// cycles since the last hsync rise and length of the current low pulse
	always_ff @(posedge clk) begin
		if (rst) begin
			hs_prev    <= 1'b1;
			seen_rise  <= 1'b0;
			since_rise <= 10'd0;
			low_len    <= 10'd0;
		end else begin
			hs_prev <= vga_hsync;
			if (hs_rise) begin
				seen_rise  <= 1'b1;
				since_rise <= 10'd1;
			end else begin
				since_rise <= since_rise + 10'd1;
			end
			if (vga_hsync)
				low_len <= 10'd0;
			else
				low_len <= low_len + 10'd1;
		end
	end

	// glyph box is 8x16 in the top left corner
	always_comb begin
		glyph_row = 8'h00;
		if (key_valid && last_key == kbd_pkg::KEY_Q)
			glyph_row = kbd_pkg::GLYPH_Q[v_addr[3:0]];
		else if (key_valid && last_key == kbd_pkg::KEY_D)
			glyph_row = kbd_pkg::GLYPH_D[v_addr[3:0]];
		exp_pixel = (v_addr < 10'd16) && (h_addr < 10'd8) && glyph_row[3'd7 - h_addr[2:0]];
	end

	hsync_period: assert property (@(posedge clk) disable iff (rst)
		hs_rise && seen_rise |-> since_rise == kbd_pkg::H_TOTAL)
	else begin
		fail_count++;
		$error("hsync period was %0d cycles", since_rise);
	end

	hsync_width: assert property (@(posedge clk) disable iff (rst)
		hs_rise |-> low_len == kbd_pkg::H_SYNC)
	else begin
		fail_count++;
		$error("hsync low for %0d cycles", low_len);
	end

	// vsync edges line up with the first pixel of a line
	vsync_fall: assert property (@(posedge clk) disable iff (rst)
		$fell(vga_vsync) |->
			$past(v_addr, 2) == kbd_pkg::V_ACTIVE + kbd_pkg::V_FRONT &&
			$past(h_addr, 2) == 10'd0)
	else begin
		fail_count++;
		$error("vsync fell at the wrong line or column");
	end

	vsync_rise: assert property (@(posedge clk) disable iff (rst)
		$rose(vga_vsync) |->
			$past(v_addr, 2) == kbd_pkg::V_ACTIVE + kbd_pkg::V_FRONT + kbd_pkg::V_SYNC &&
			$past(h_addr, 2) == 10'd0)
	else begin
		fail_count++;
		$error("vsync rose at the wrong line or column");
	end

	blank_in_vblank: assert property (@(posedge clk) disable iff (rst)
		v_addr >= kbd_pkg::V_ACTIVE |-> !vga_blank_n)
	else begin
		fail_count++;
		$error("blank_n high on line %0d", v_addr);
	end

	// two cycles from address to colour
	pixel_colour: assert property (@(posedge clk) disable iff (rst)
		{vga_r, vga_g, vga_b, led_pixel} == {25{$past(exp_pixel, 2)}})
	else begin
		fail_count++;
		$error("colour outputs do not match the glyph");
	end

	code_valid_pulse: assert property (@(posedge clk) disable iff (rst)
		code_valid |=> !code_valid)
	else begin
		fail_count++;
		$error("code_valid held for more than one cycle");
	end

	parity_sticky: assert property (@(posedge clk) disable iff (rst)
		parity_error |=> parity_error)
	else begin
		fail_count++;
		$error("parity_error cleared without reset");
	end

endmodule

bind kbd_display_top kbd_display_checker kbd_display_checker_inst (
	.clk          (clk),
	.rst          (rst),
	.vga_hsync    (vga_hsync),
	.vga_vsync    (vga_vsync),
	.vga_blank_n  (vga_blank_n),
	.vga_r        (vga_r),
	.vga_g        (vga_g),
	.vga_b        (vga_b),
	.led_pixel    (ledr[0]),
	.h_addr       (h_addr),
	.v_addr       (v_addr),
	.last_key     (last_key),
	.key_valid    (key_valid),
	.code_valid   (code_valid),
	.parity_error (parity_error)
);

// ==== tests/kbd_display_tb.sv ====
module kbd_display_tb;

	localparam int CLK_PERIOD   = 20;
	localparam int BIT_CYCLES   = 40;
	// idle gap plus eleven bits
	localparam int FRAME_CYCLES = 12 * BIT_CYCLES;
	localparam int N_RANDOM     = 6;
	localparam int N_FRAMES     = N_RANDOM + 1 + 7 + 3;
	localparam int VGA_FRAME    = int'(kbd_pkg::H_TOTAL) * int'(kbd_pkg::V_TOTAL);
	// vga test and three glyph keys take up to a frame each plus one spare
	localparam int TIMEOUT      = (N_FRAMES * FRAME_CYCLES + 5 * VGA_FRAME) * CLK_PERIOD;

	logic        clk;
	logic        rst;
	logic        ps2_clk;
	logic        ps2_data;
	logic        vga_hsync;
	logic        vga_vsync;
	logic        vga_blank_n;
	logic [7:0]  vga_r;
	logic [7:0]  vga_g;
	logic [7:0]  vga_b;
	logic [7:0]  seg0;
	logic [7:0]  seg1;
	logic [7:0]  seg4;
	logic [7:0]  seg5;
	logic [15:0] ledr;

	int         seed;
	int         test_errors;
	int         checker_mark;
	int         tests_run;
	int         tests_failed;
	logic [7:0] key_byte;
	logic [3:0] releases;
	logic [7:0] seg0_before;
	logic [7:0] seg1_before;

	tb_clock tb_clock_inst (
		.clk (clk),
		.rst (rst)
	);

	kbd_display_top kbd_display_top_inst (
		.clk         (clk),
		.rst         (rst),
		.ps2_clk     (ps2_clk),
		.ps2_data    (ps2_data),
		.vga_hsync   (vga_hsync),
		.vga_vsync   (vga_vsync),
		.vga_blank_n (vga_blank_n),
		.vga_r       (vga_r),
		.vga_g       (vga_g),
		.vga_b       (vga_b),
		.seg0        (seg0),
		.seg1        (seg1),
		.seg4        (seg4),
		.seg5        (seg5),
		.ledr        (ledr)
	);

	// inputs change just after the rising edge
	task automatic step(input int n);
		repeat (n) @(posedge clk);
		#2;
	endtask

	// returns 4 cycles after the stop-bit falling edge with ps2_clk still low
	task automatic send_frame(input logic [7:0] data, input logic bad_parity);
		logic [10:0] bits;
		bits = {1'b1, (~^data) ^ bad_parity, data, 1'b0};
		ps2_clk = 1'b1;
		step(BIT_CYCLES);
		for (int i = 0; i < 11; i++) begin
			ps2_data = bits[i];
			step(BIT_CYCLES / 2);
			ps2_clk = 1'b0;
			if (i < 10) begin
				step(BIT_CYCLES / 2);
				ps2_clk = 1'b1;
			end
		end
		step(4);
	endtask

	task automatic check_value(input string name, input string what,
		input logic [15:0] expected, input logic [15:0] actual);
		assert (expected == actual) else begin
			$display("Fail %s %s: expected %h, actual %h", name, what, expected, actual);
			test_errors++;
		end
	endtask

	task automatic check_key(input string name, input logic [7:0] key);
		check_value(name, "seg0", {8'h00, ~kbd_pkg::SEG_HEX[key[3:0]]}, {8'h00, seg0});
		check_value(name, "seg1", {8'h00, ~kbd_pkg::SEG_HEX[key[7:4]]}, {8'h00, seg1});
		check_value(name, "led key", {8'h00, key}, {8'h00, ledr[14:7]});
		check_value(name, "led valid", 16'd1, {15'd0, ledr[2]});
	endtask

	task automatic check_release(input string name);
		check_value(name, "seg4", {8'h00, ~kbd_pkg::SEG_HEX[releases]}, {8'h00, seg4});
		check_value(name, "seg5", {8'h00, ~kbd_pkg::SEG_HEX[0]}, {8'h00, seg5});
		check_value(name, "led count", {12'd0, releases}, {12'd0, ledr[6:3]});
	endtask

	task automatic start_test();
		test_errors = 0;
		checker_mark = kbd_display_top_inst.kbd_display_checker_inst.fail_count;
	endtask

	task automatic finish_test(input string name);
		int assert_fails;
		assert_fails = kbd_display_top_inst.kbd_display_checker_inst.fail_count - checker_mark;
		tests_run++;
		if (test_errors == 0 && assert_fails == 0) begin
			$display("%s: ok", name);
		end else begin
			tests_failed++;
			$display("%s: %0d wrong values and %0d failed assertions", name, test_errors,
				assert_fails);
		end
	endtask

	// back porch then glyph lines 0..15 after vsync ends
	task automatic scan_top_lines();
		@(posedge vga_vsync);
		repeat (kbd_pkg::V_BACK + 10'd16) @(posedge vga_hsync);
		step(1);
	endtask

	task automatic glyph_test(input string name, input logic [7:0] key);
		start_test();
		send_frame(key, 1'b0);
		check_key(name, key);
		scan_top_lines();
		finish_test(name);
	endtask

	initial begin
		#(TIMEOUT);
		$display("timeout: the tests did not finish in time");
		$display("test failed");
		$finish;
	end

	initial begin
		seed = 32'h66abe3a4;
		ps2_clk = 1'b1;
		ps2_data = 1'b1;
		tests_run = 0;
		tests_failed = 0;
		releases = 4'd0;
		@(negedge rst);
		step(1);

		start_test();
		@(posedge vga_vsync);
		step(1);
		check_value("vga_timing", "blank_n", 16'd0, {15'd0, vga_blank_n});
		finish_test("vga_timing");

		start_test();
		for (int n = 0; n < N_RANDOM; n++) begin
			key_byte = 8'($random(seed));
			while (key_byte == kbd_pkg::EXT_CODE || key_byte == kbd_pkg::BREAK_CODE)
				key_byte = 8'($random(seed));
			send_frame(key_byte, 1'b0);
			check_key("good_frames", key_byte);
		end
		finish_test("good_frames");

		start_test();
		seg0_before = seg0;
		seg1_before = seg1;
		check_value("bad_parity", "parity led", 16'd0, {15'd0, ledr[1]});
		send_frame(8'h2C, 1'b1);
		check_value("bad_parity", "parity led", 16'd1, {15'd0, ledr[1]});
		check_value("bad_parity", "seg0", {8'h00, seg0_before}, {8'h00, seg0});
		check_value("bad_parity", "seg1", {8'h00, seg1_before}, {8'h00, seg1});
		finish_test("bad_parity");

		start_test();
		send_frame(kbd_pkg::EXT_CODE, 1'b0);
		send_frame(8'h74, 1'b0);
		check_key("release", 8'h74);
		send_frame(kbd_pkg::BREAK_CODE, 1'b0);
		send_frame(8'h74, 1'b0);
		releases = releases + 4'd1;
		check_release("release");
		check_key("release", 8'h74);
		// extended release of another key
		send_frame(kbd_pkg::EXT_CODE, 1'b0);
		send_frame(kbd_pkg::BREAK_CODE, 1'b0);
		send_frame(8'h6B, 1'b0);
		releases = releases + 4'd1;
		check_release("release");
		check_key("release", 8'h74);
		finish_test("release");

		glyph_test("glyph_q", kbd_pkg::KEY_Q);
		glyph_test("glyph_d", kbd_pkg::KEY_D);
		glyph_test("glyph_other", 8'h1C);

		$display("%0d tests run, %0d passed, %0d failed", tests_run, tests_run - tests_failed,
			tests_failed);
		if (tests_failed == 0 && kbd_display_top_inst.kbd_display_checker_inst.fail_count == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

// ==== tests/tb_clock.sv ====
module tb_clock (
	output logic clk,
	output logic rst
);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// reset released just after the eighth rising edge
	initial begin
		rst = 1'b1;
		repeat (8) @(posedge clk);
		#2 rst = 1'b0;
	end

endmodule
